//--- testbench/lsu_tests.txt
# is_store funct3 rs1 imm rs2 ack_delay mem_word | expected adr sel dat rd misalign
# hex except ack_delay (decimal, below zero is random); dat matters on stores only
0 2 00001000 00000020 00000000  0 deadbeef 00001020 f 00000000 deadbeef 0
0 2 20000010 fffffff4 00000000  3 12345678 20000004 f 00000000 12345678 0
0 0 00000100 00000000 00000000  1 80f17f22 00000100 1 00000000 00000022 0
0 0 00000100 00000001 00000000  0 80f17f22 00000101 2 00000000 0000007f 0
0 0 00000101 00000001 00000000  2 80f17f22 00000102 4 00000000 fffffff1 0
0 0 000000ff 00000004 00000000  0 80f17f22 00000103 8 00000000 ffffff80 0
0 4 00000102 00000000 00000000  1 80f17f22 00000102 4 00000000 000000f1 0
0 4 00000003 00000100 00000000  0 80f17f22 00000103 8 00000000 00000080 0
0 1 00002000 00000000 00000000  0 9abc7654 00002000 3 00000000 00007654 0
0 1 00002000 00000002 00000000  4 9abc7654 00002002 c 00000000 ffff9abc 0
0 1 00003004 fffffffc 00000000  1 0000ff80 00003000 3 00000000 ffffff80 0
0 5 00001ffe 00000004 00000000  0 9abc7654 00002002 c 00000000 00009abc 0
1 2 00004000 00000008 a1b2c3d4  2 00000000 00004008 f a1b2c3d4 00000000 0
1 0 00004000 00000000 a1b2c3d4  0 00000000 00004000 1 d4d4d4d4 00000000 0
1 0 00004001 00000002 a1b2c3d4  1 00000000 00004003 8 d4d4d4d4 00000000 0
1 1 00004000 00000000 a1b2c3d4  0 00000000 00004000 3 c3d4c3d4 00000000 0
1 1 00004000 00000002 a1b2c3d4  5 00000000 00004002 c c3d4c3d4 00000000 0
0 2 00005000 00000001 00000000  0 00000000 00005001 f 00000000 00000000 1
0 2 00005002 00000000 00000000  0 00000000 00005002 f 00000000 00000000 1
0 1 00005000 00000003 00000000  0 00000000 00005003 c 00000000 00000000 1
1 1 00005000 00000001 a1b2c3d4  0 00000000 00005001 3 c3d4c3d4 00000000 1
0 2 0000a000 00000010 00000000 -1 cafef00d 0000a010 f 00000000 cafef00d 0
0 4 0000a001 00000000 00000000 -1 cafef00d 0000a001 2 00000000 000000f0 0
1 1 0000a000 00000002 0000beef -1 00000000 0000a002 c beefbeef 00000000 0
1 0 0000a002 00000000 ffffff5a -1 00000000 0000a002 4 5a5a5a5a 00000000 0
0 2 fffffffc 00000008 00000000 12 0badc0de 00000004 f 00000000 0badc0de 0

//--- build.f
src/lsu_pkg.sv
src/ser_add.sv
src/lsu_mem_if.sv
src/lsu_seq.sv
src/lsu_top.sv
testbench/tb_lsu.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_lsu
FILELIST  = build.f
LOG       = sim.log
PASS_MSG  = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
   import lsu_pkg::*;
();

   typedef struct packed {
      lsu_cmd_t        cmd;
      int              delay;          // below zero draws a random delay.
      logic [xlen-1:0] mem_word;
      logic [xlen-1:0] adr;
      logic [3:0]      sel;
      logic [xlen-1:0] dat;
      logic [xlen-1:0] rd;
      logic            misalign;
   } test_t;

   logic            clk;
   logic            rst_n;
   lsu_cmd_t        cmd;
   logic            cmd_valid;
   logic            busy;
   logic            done;
   lsu_rsp_t        rsp;
   wb_req_t         wb_req;
   wb_rsp_t         wb_rsp;

   test_t           tests[$];
   logic [31:0]     lcg_state;
   int              cur_delay;
   logic [xlen-1:0] cur_mem;
   int              budget;
   int              total_err;
   int              n_fail;

   lsu_top i_dut (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_cmd       (cmd),
      .i_cmd_valid (cmd_valid),
      .o_busy      (busy),
      .o_done      (done),
      .o_rsp       (rsp),
      .o_wb        (wb_req),
      .i_wb        (wb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // memory model that acks after cur_delay cycles of cyc.
   initial begin : responder
      int ack_cnt;
      ack_cnt = 0;
      wb_rsp  = '0;
      forever begin
         @(posedge clk);
         wb_rsp.ack <= 1'b0;
         wb_rsp.rdt <= ~cur_mem;                    // junk outside the ack cycle.
         if (!rst_n) begin
            ack_cnt = 0;
         end else if (wb_req.cyc && !wb_rsp.ack) begin
            if (ack_cnt >= cur_delay) begin
               wb_rsp.ack <= 1'b1;
               wb_rsp.rdt <= cur_mem;
               ack_cnt = 0;
            end else begin
               ack_cnt++;
            end
         end
      end
   end

   task automatic load_tests(output bit ok);
      int              fd;
      int              n;
      int              f_delay;
      string           line;
      test_t           t;
      logic [xlen-1:0] f[11];
      ok = 1'b1;
      fd = $fopen("testbench/lsu_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open testbench/lsu_tests.txt");
         ok = 1'b0;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %d %h %h %h %h %h %h", f[0], f[1], f[2],
                           f[3], f[4], f_delay, f[5], f[6], f[7], f[8], f[9], f[10]);
               if (n != 12) begin
                  $display("unreadable line in test file: %s", line);
                  ok = 1'b0;
               end else begin
                  t.cmd.is_store = f[0][0];
                  t.cmd.funct3   = f[1][2:0];
                  t.cmd.rs1      = f[2];
                  t.cmd.imm      = f[3];
                  t.cmd.rs2      = f[4];
                  t.delay        = f_delay;
                  t.mem_word     = f[5];
                  t.adr          = f[6];
                  t.sel          = f[7][3:0];
                  t.dat          = f[8];
                  t.rd           = f[9];
                  t.misalign     = f[10][0];
                  tests.push_back(t);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_value(input int idx, input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] want, inout int errs);
      if (got !== want) begin
         $display("MISMATCH test %0d %s: got %h expected %h", idx, name, got, want);
         errs++;
      end
   endtask

   task automatic run_test(input int idx, input test_t t);
      int       delay;
      int       k;
      int       cyc_at;
      int       ack_at;
      int       errs;
      bit       fin;
      wb_req_t  req0;
      lsu_cmd_t bogus;
      delay  = ($signed(t.delay) < 0) ? int'(next_random() >> 29) : t.delay;
      bogus  = ~t.cmd;
      cyc_at = -1;
      ack_at = -1;
      errs   = 0;
      fin    = 1'b0;
      k      = 0;
      @(posedge clk);
      cmd       <= t.cmd;
      cmd_valid <= 1'b1;
      cur_delay <= delay;
      cur_mem   <= t.mem_word;
      @(posedge clk);                                // accept edge.
      cmd_valid <= 1'b0;
      while (!fin) begin
         @(negedge clk);
         if (k == 1 && !busy) begin
            $display("test %0d: busy is low right after the command", idx);
            errs++;
         end
         if (wb_req.cyc) begin
            if (cyc_at < 0) begin
               cyc_at = k;
               req0   = wb_req;
            end else if ({wb_req.adr, wb_req.dat, wb_req.sel, wb_req.we}
                         !== {req0.adr, req0.dat, req0.sel, req0.we}) begin
               $display("test %0d: bus request changed while cyc was high", idx);
               errs++;
            end
            if (wb_rsp.ack) begin
               ack_at = k;
            end
         end
         if (ack_at >= 0 && k == ack_at + 1 && wb_req.cyc) begin
            $display("test %0d: cyc still high in the cycle after ack", idx);
            errs++;
         end
         if (done) begin
            fin = 1'b1;
         end else begin
            @(posedge clk);
            k++;
            if (k == 3) begin
               cmd       <= bogus;                   // must be ignored while busy.
               cmd_valid <= 1'b1;
            end else if (k == 4) begin
               cmd_valid <= 1'b0;
            end
         end
      end
      if (busy) begin
         $display("test %0d: busy still high with done", idx);
         errs++;
      end
      if (t.misalign) begin
         if (cyc_at >= 0) begin
            $display("test %0d: bus cycle started on a misaligned access", idx);
            errs++;
         end
         if (k != 32) begin
            $display("test %0d: done came %0d cycles after accept, expected 32", idx, k);
            errs++;
         end
      end else if (cyc_at != 33 || ack_at < 0) begin
         $display("test %0d: cyc rose %0d cycles after accept, expected 33", idx, cyc_at);
         errs++;
      end else begin
         if (k != ack_at + (t.cmd.is_store ? 1 : 33)) begin
            $display("test %0d: done came %0d cycles after ack", idx, k - ack_at);
            errs++;
         end
         check_value(idx, "adr", req0.adr, t.adr, errs);
         check_value(idx, "sel", {28'h0, req0.sel}, {28'h0, t.sel}, errs);
         check_value(idx, "we", {31'h0, req0.we}, {31'h0, t.cmd.is_store}, errs);
         if (t.cmd.is_store) begin
            check_value(idx, "dat", req0.dat, t.dat, errs);
         end
      end
      check_value(idx, "rd", rsp.rd, t.rd, errs);
      check_value(idx, "misalign", {31'h0, rsp.misalign}, {31'h0, t.misalign}, errs);
      if (errs == 0) begin
         $display("test %0d: ok", idx);
      end else begin
         $display("test %0d: %0d errors", idx, errs);
         n_fail++;
      end
      total_err += errs;
   endtask

   initial begin : watchdog
      wait (budget != 0);
      repeat (budget) @(posedge clk);
      $display("watchdog: tests did not finish within %0d cycles", budget);
      $display("sim failed");
      $finish;
   end

   initial begin : main
      bit ok;
      int cycles;
      rst_n     = 1'b0;
      cmd       = '0;
      cmd_valid = 1'b0;
      cur_delay = 0;
      cur_mem   = '0;
      lcg_state = 32'd44;
      total_err = 0;
      n_fail    = 0;
      budget    = 0;
      cycles    = 0;
      load_tests(ok);
      if (!ok || tests.size() == 0) begin
         $display("no usable tests in testbench/lsu_tests.txt");
         $display("sim failed");
      end else begin
         foreach (tests[i]) begin
            cycles += 40 + xlen * 2 + (($signed(tests[i].delay) < 0) ? 7 : tests[i].delay);
         end
         budget = cycles + 100;
         repeat (2) @(posedge clk);
         rst_n <= 1'b1;
         foreach (tests[i]) begin
            run_test(i, tests[i]);
         end
         $display("tests: %0d run, %0d passed, %0d failed",
                  tests.size(), tests.size() - n_fail, n_fail);
         if (total_err == 0) begin
            $display("sim passed");
         end else begin
            $display("sim failed");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
   import lsu_pkg::*;
(
   input  wire           i_clk,
   input  wire           i_rst_n,
   input  wire lsu_cmd_t i_cmd,
   input  wire           i_cmd_valid,
   output logic          o_busy,
   output logic          o_done,
   output lsu_rsp_t      o_rsp,
   output wb_req_t       o_wb,
   input  wire wb_rsp_t  i_wb
);

   logic       en;
   logic       init;
   logic [1:0] bytecnt;
   logic [2:0] funct3;
   logic       we;
   logic       rs1;
   logic       rs2;
   logic       imm;
   logic       rd;
   logic       misalign;
   logic       ack_seen;

   lsu_seq u_seq (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_cmd       (i_cmd),
      .i_cmd_valid (i_cmd_valid),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_rsp       (o_rsp),
      .o_en        (en),
      .o_init      (init),
      .o_bytecnt   (bytecnt),
      .o_funct3    (funct3),
      .o_we        (we),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_imm       (imm),
      .i_rd        (rd),
      .i_misalign  (misalign),
      .i_ack_seen  (ack_seen)
   );

   lsu_mem_if u_mem_if (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_en       (en),
      .i_init     (init),
      .i_bytecnt  (bytecnt),
      .i_funct3   (funct3),
      .i_we       (we),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .o_rd       (rd),
      .o_misalign (misalign),
      .o_ack_seen (ack_seen),
      .o_wb       (o_wb),
      .i_wb       (i_wb)
   );

endmodule

`default_nettype wire

//--- src/lsu_seq.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_seq
   import lsu_pkg::*;
(
   input  wire           i_clk,
   input  wire           i_rst_n,
   input  wire lsu_cmd_t i_cmd,
   input  wire           i_cmd_valid,
   output logic          o_busy,
   output logic          o_done,
   output lsu_rsp_t      o_rsp,
   output logic          o_en,
   output logic          o_init,
   output logic [1:0]    o_bytecnt,
   output logic [2:0]    o_funct3,
   output logic          o_we,
   output logic          o_rs1,
   output logic          o_rs2,
   output logic          o_imm,
   input  wire           i_rd,
   input  wire           i_misalign,
   input  wire           i_ack_seen
);

   typedef enum logic [1:0] {
      st_idle,
      st_init,
      st_wait,
      st_read
   } state_t;

   state_t           state;
   logic [cnt_w-1:0] cnt;
   logic             last;
   logic             accept;
   logic             done_r;
   logic             mis_r;

   logic [xlen-1:0]  rs1_sr;
   logic [xlen-1:0]  imm_sr;
   logic [xlen-1:0]  rs2_sr;
   logic [xlen-1:0]  rd_sr;
   logic [2:0]       funct3_r;
   logic             we_r;

   assign accept = i_cmd_valid & (state == st_idle);   // strobes while busy drop.
   assign last   = (cnt == cnt_w'(xlen - 1));

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state  <= st_idle;
         cnt    <= '0;
         done_r <= 1'b0;
         mis_r  <= 1'b0;
      end else begin
         done_r <= 1'b0;
         case (state)
            st_idle: begin
               if (i_cmd_valid) begin
                  state <= st_init;
                  cnt   <= '0;
                  mis_r <= 1'b0;
               end
            end
            st_init: begin
               cnt <= cnt + 1'b1;                        // wraps to zero for read.
               if (last) begin
                  if (i_misalign) begin
                     mis_r  <= 1'b1;
                     done_r <= 1'b1;
                     state  <= st_idle;
                  end else begin
                     state <= st_wait;
                  end
               end
            end
            st_wait: begin
               if (i_ack_seen) begin
                  if (we_r) begin
                     done_r <= 1'b1;
                     state  <= st_idle;
                  end else begin
                     state <= st_read;
                  end
               end
            end
            st_read: begin
               cnt <= cnt + 1'b1;
               if (last) begin
                  done_r <= 1'b1;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // operands go out lsb first, load bits come back lsb first.
   always_ff @(posedge i_clk) begin
      if (accept) begin
         rs1_sr   <= i_cmd.rs1;
         imm_sr   <= i_cmd.imm;
         rs2_sr   <= i_cmd.rs2;
         funct3_r <= i_cmd.funct3;
         we_r     <= i_cmd.is_store;
         rd_sr    <= '0;
      end else begin
         if (state == st_init) begin
            rs1_sr <= {1'b0, rs1_sr[xlen-1:1]};
            imm_sr <= {1'b0, imm_sr[xlen-1:1]};
            rs2_sr <= {1'b0, rs2_sr[xlen-1:1]};
         end
         if (state == st_read) begin
            rd_sr <= {i_rd, rd_sr[xlen-1:1]};
         end
      end
   end

   assign o_busy    = (state != st_idle);
   assign o_done    = done_r;
   assign o_rsp     = '{rd: rd_sr, misalign: mis_r};
   assign o_en      = (state == st_init) | (state == st_read);
   assign o_init    = (state == st_init);
   assign o_bytecnt = cnt[cnt_w-1 -: 2];                 // current byte of the word.
   assign o_funct3  = funct3_r;
   assign o_we      = we_r;
   assign o_rs1     = rs1_sr[0];
   assign o_rs2     = rs2_sr[0];
   assign o_imm     = imm_sr[0];

endmodule

`default_nettype wire

//--- src/lsu_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_if
   import lsu_pkg::*;
(
   input  wire          i_clk,
   input  wire          i_rst_n,
   input  wire          i_en,
   input  wire          i_init,
   input  wire  [1:0]   i_bytecnt,
   input  wire  [2:0]   i_funct3,
   input  wire          i_we,
   input  wire          i_rs1,
   input  wire          i_rs2,
   input  wire          i_imm,
   output logic         o_rd,
   output logic         o_misalign,
   output logic         o_ack_seen,
   output wb_req_t      o_wb,
   input  wire wb_rsp_t i_wb
);

   logic            sum;
   logic            init_r;
   logic            init_2r;
   logic [1:0]      misalign_r;
   logic            cyc_r;
   logic [xlen-1:0] adr_r;
   logic [1:0]      bytepos;
   logic [3:0][7:0] lane;
   logic            signbit;

   logic            is_word;
   logic            is_half;
   logic            is_byte;
   logic            is_signed;
   logic            first_bit;
   logic            second_bit;
   logic            init_done;
   logic [1:0]      dat_sel;
   logic            dat_valid;
   logic            dat_cur;
   logic [3:0]      wr_en;
   logic [3:0]      rd_en;
   logic [3:0]      lane_en;
   logic [3:0]      sel;

   ser_add u_adr_add (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_clr   (~i_init),
      .i_a     (i_rs1),
      .i_b     (i_imm),
      .o_q     (sum)
   );

   assign is_word   = i_funct3[1];
   assign is_half   = i_funct3[0] & ~i_funct3[1];
   assign is_byte   = ~|i_funct3[1:0];
   assign is_signed = ~i_funct3[2];

   assign first_bit  = i_init & ~init_r;              // address bit 0 on sum.
   assign second_bit = i_init & init_r & ~init_2r;    // address bit 1 on sum.
   assign init_done  = init_r & ~i_init;

   assign o_misalign = |misalign_r;
   assign o_ack_seen = cyc_r & i_wb.ack;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         init_r     <= 1'b0;
         init_2r    <= 1'b0;
         misalign_r <= 2'b00;
         cyc_r      <= 1'b0;
      end else begin
         init_r  <= i_init;
         init_2r <= init_r;
         if (!i_en) begin
            misalign_r <= 2'b00;
         end else if (first_bit) begin
            misalign_r[0] <= ~is_byte & sum;
         end else if (second_bit) begin
            misalign_r[1] <= is_word & sum;
         end
         if (o_ack_seen) begin
            cyc_r <= 1'b0;
         end else if (init_done && !o_misalign) begin
            cyc_r <= 1'b1;
         end
      end
   end

   // store lanes fill so that narrow data ends up replicated.
   always_comb begin
      wr_en[0] = (i_bytecnt == 2'd0);
      wr_en[1] = (i_bytecnt == 2'd0) | ((i_bytecnt == 2'd1) & ~is_byte);
      wr_en[2] = (i_bytecnt == 2'd0) | ((i_bytecnt == 2'd2) & is_word);
      wr_en[3] = (i_bytecnt == 2'd0)
               | ((i_bytecnt == 2'd1) & is_half)
               | ((i_bytecnt == 2'd3) & is_word);
   end

   assign dat_sel   = i_bytecnt[1] ? i_bytecnt : (i_bytecnt | bytepos);
   assign dat_valid = is_word | (i_bytecnt == 2'd0) | (is_half & ~i_bytecnt[1]);
   assign dat_cur   = lane[dat_sel][0];
   assign rd_en     = 4'b0001 << dat_sel;
   assign lane_en   = i_init ? wr_en : (i_en ? rd_en : 4'b0000);

   assign o_rd = dat_valid ? dat_cur : (signbit & is_signed);   // extend past width.

   always_ff @(posedge i_clk) begin
      if (i_init) begin
         adr_r <= {sum, adr_r[xlen-1:1]};
      end
      if (first_bit) begin
         bytepos[0] <= sum;
      end
      if (second_bit) begin
         bytepos[1] <= sum;
      end
      for (int k = 0; k < 4; k++) begin
         if (lane_en[k]) begin
            lane[k] <= {i_rs2, lane[k][7:1]};
         end
      end
      if (o_ack_seen && !i_we) begin
         lane <= i_wb.rdt;                          // load data lands here.
      end
      if (i_en && dat_valid) begin
         signbit <= dat_cur;
      end
   end

   always_comb begin
      if (is_word) begin
         sel = 4'b1111;
      end else if (is_half) begin
         sel = {{2{bytepos[1]}}, {2{~bytepos[1]}}};
      end else begin
         sel = 4'b0001 << bytepos;
      end
   end

   assign o_wb = '{adr: adr_r, dat: lane, sel: sel, we: i_we, cyc: cyc_r};

endmodule

`default_nettype wire

//--- src/ser_add.sv
`timescale 1ns/1ps
`default_nettype none

module ser_add (
   input  wire  i_clk,
   input  wire  i_rst_n,
   input  wire  i_clr,
   input  wire  i_a,
   input  wire  i_b,
   output logic o_q
);

   logic carry;
   logic carry_nxt;

   assign o_q       = i_a ^ i_b ^ carry;                          // sum bit.
   assign carry_nxt = (i_a & i_b) | (i_a & carry) | (i_b & carry);

   // carry starts from zero for each new operand pair.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else if (i_clr) begin
         carry <= 1'b0;
      end else begin
         carry <= carry_nxt;
      end
   end

endmodule

`default_nettype wire

//--- src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   localparam int xlen  = 32;             // data and address width.
   localparam int cnt_w = $clog2(xlen);   // one count per serial bit.

   // one memory instruction as handed over by the core.
   typedef struct packed {
      logic            is_store;
      logic [2:0]      funct3;            // riscv width and sign code.
      logic [xlen-1:0] rs1;
      logic [xlen-1:0] imm;
      logic [xlen-1:0] rs2;
   } lsu_cmd_t;

   // completion, valid with the done pulse.
   typedef struct packed {
      logic [xlen-1:0] rd;                // zero for stores and traps.
      logic            misalign;
   } lsu_rsp_t;

   // master to slave.
   typedef struct packed {
      logic [xlen-1:0] adr;
      logic [xlen-1:0] dat;
      logic [3:0]      sel;
      logic            we;
      logic            cyc;
   } wb_req_t;

   // slave to master.
   typedef struct packed {
      logic [xlen-1:0] rdt;
      logic            ack;
   } wb_rsp_t;

endpackage

`default_nettype wire
